// ==== build.f ====
rv_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_apb_mem.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_idu.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_lsu.sv
  - rv_core.sv
  - target: test
    files:
      - tb_apb_mem.sv
      - tb_rv_core.sv

// ==== tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [63:0] RESET_PC = 64'h0000_0000_0000_1000;
   localparam logic [6:0] OP_LUI = 7'b0110111;
   localparam logic [6:0] OP_AUIPC = 7'b0010111;
   localparam logic [6:0] OP_JALR = 7'b1100111;
   localparam logic [6:0] OP_LOAD = 7'b0000011;
   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_REG = 7'b0110011;

   logic clk = 1'b0;
   logic i_reset;
   logic i_insn_valid;
   rv_pkg::insn_u i_insn;
   logic o_insn_ready;
   rv_pkg::apb_req_t apb_req;
   rv_pkg::apb_rsp_t apb_rsp;
   rv_pkg::retire_t o_retire;
   logic [63:0] o_pc;

   logic [63:0] regs [32];
   logic [63:0] exp_mem [512];
   logic [63:0] exp_pc;
   logic [31:0] rand_state = 32'd60721;
   int err_count = 0;

   always #5 clk = ~clk;

   rv_core #(.RESET_PC(RESET_PC)) rv_core_inst (
      .i_clk        (clk),
      .i_reset      (i_reset),
      .i_insn_valid (i_insn_valid),
      .i_insn       (i_insn),
      .o_insn_ready (o_insn_ready),
      .o_apb        (apb_req),
      .i_apb        (apb_rsp),
      .o_retire     (o_retire),
      .o_pc         (o_pc)
   );

   tb_apb_mem mem_inst (
      .i_clk   (clk),
      .i_reset (i_reset),
      .i_req   (apb_req),
      .o_rsp   (apb_rsp)
   );

   function automatic logic [31:0] lcg_next();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic logic [63:0] sext12(input logic [11:0] v);
      return {{52{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {7'b0000000, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // integer results by funct3 as the ISA defines them for OP and OP-IMM
   function automatic logic [63:0] op_ref(input logic [2:0] f3, input logic [63:0] a,
                                          input logic [63:0] b);
      case (f3)
         3'b000: return a + b;
         3'b001: return a << b[5:0];
         3'b010: return {63'd0, $signed(a) < $signed(b)};
         3'b011: return {63'd0, a < b};
         default: return a | b;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
      case (f3)
         3'b000: return a == b;
         3'b001: return a != b;
         3'b100: return $signed(a) < $signed(b);
         3'b101: return $signed(a) >= $signed(b);
         3'b110: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [63:0] load_ref(input logic [2:0] f3, input logic [63:0] dword,
                                            input logic [2:0] lane);
      logic [63:0] w;
      w = dword >> {lane, 3'b000};
      case (f3)
         3'b000: return {{56{w[7]}}, w[7:0]};
         3'b001: return {{48{w[15]}}, w[15:0]};
         3'b010: return {{32{w[31]}}, w[31:0]};
         3'b100: return {56'd0, w[7:0]};
         3'b101: return {48'd0, w[15:0]};
         3'b110: return {32'd0, w[31:0]};
         default: return w;
      endcase
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout at %0t ns: %s", $time, what);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
   endtask

   // holds the word until a negedge shows ready, then drops valid at the accepting edge
   task automatic send_insn(input logic [31:0] word);
      int cycles;
      cycles = 0;
      @(posedge clk);
      i_insn_valid <= 1'b1;
      i_insn <= word;
      @(negedge clk);
      while (!o_insn_ready) begin
         cycles++;
         if (cycles > 200) fail_timeout("the core never raised o_insn_ready");
         @(negedge clk);
      end
      @(posedge clk);
      i_insn_valid <= 1'b0;
   endtask

   task automatic wait_retire();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!o_retire.valid) begin
         cycles++;
         if (cycles > 200) fail_timeout("no instruction retired");
         @(negedge clk);
      end
   endtask

   task automatic check_retire(input logic [31:0] word, input logic exp_we,
                               input logic [63:0] exp_wdata, input logic [63:0] exp_next);
      check("o_retire.pc", o_retire.pc, exp_pc);
      check("o_retire.next_pc", o_retire.next_pc, exp_next);
      check("o_retire.we", o_retire.we, exp_we);
      if (exp_we) begin
         check("o_retire.rd", o_retire.rd, word[11:7]);
         check("o_retire.wdata", o_retire.wdata, exp_wdata);
         if (word[11:7] != 5'd0) regs[word[11:7]] = exp_wdata;
      end
      check("o_pc", o_pc, exp_next);
      exp_pc = exp_next;
   endtask

   task automatic run_insn(input logic [31:0] word, input logic exp_we,
                           input logic [63:0] exp_wdata, input logic [63:0] exp_next);
      send_insn(word);
      wait_retire();
      check_retire(word, exp_we, exp_wdata, exp_next);
   endtask

   task automatic do_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
      run_insn(enc_i(imm, rs1, f3, rd, OP_IMM), 1'b1, op_ref(f3, regs[rs1], sext12(imm)),
               exp_pc + 4);
   endtask

   task automatic do_reg(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2);
      run_insn(enc_r(rs2, rs1, f3, rd), 1'b1, op_ref(f3, regs[rs1], regs[rs2]), exp_pc + 4);
   endtask

   // addi, slli and ori build a wide random value
   task automatic load_random(input logic [4:0] rd);
      logic [31:0] r;
      r = lcg_next();
      do_imm(3'b000, rd, 5'd0, r[11:0]);
      do_imm(3'b001, rd, rd, {7'd0, r[16:12]});
      do_imm(3'b110, rd, rd, r[28:17]);
   endtask

   task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [12:0] imm);
      logic [63:0] next;
      next = branch_ref(f3, regs[rs1], regs[rs2]) ? exp_pc + {{51{imm[12]}}, imm} : exp_pc + 4;
      run_insn(enc_b(imm, rs2, rs1, f3), 1'b0, 64'd0, next);
   endtask

   task automatic do_store(input logic [2:0] f3, input logic [4:0] rs2, input logic [2:0] off);
      logic [63:0] addr;
      addr = regs[13] + off;
      for (int b = 0; b < (1 << f3); b++) begin
         exp_mem[addr[11:3]][8*(addr[2:0]+b) +: 8] = regs[rs2][8*b +: 8];
      end
      run_insn(enc_s({9'd0, off}, rs2, 5'd13, f3), 1'b0, 64'd0, exp_pc + 4);
   endtask

   task automatic do_load(input logic [2:0] f3, input logic [4:0] rd, input logic [2:0] off);
      logic [63:0] addr;
      addr = regs[13] + off;
      run_insn(enc_i({9'd0, off}, 5'd13, f3, rd, OP_LOAD), 1'b1,
               load_ref(f3, exp_mem[addr[11:3]], addr[2:0]), exp_pc + 4);
   endtask

   task automatic test_reset_addi();
      logic [11:0] imms [5];
      imms = '{12'h005, 12'hff9, 12'h7ff, 12'h800, 12'h064};
      check("o_pc", o_pc, RESET_PC);
      check("o_insn_ready", o_insn_ready, 1'b1);
      check("o_retire.valid", o_retire.valid, 1'b0);
      check("o_apb.psel", apb_req.psel, 1'b0);
      check("o_apb.penable", apb_req.penable, 1'b0);
      for (int i = 0; i < 5; i++) begin
         do_imm(3'b000, 5'(i + 1), 5'd0, imms[i]);
      end
   endtask

   task automatic test_alu_random();
      logic [2:0] f3s [5];
      f3s = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b110};
      repeat (8) begin
         load_random(5'd6);
         load_random(5'd7);
         for (int i = 0; i < 5; i++) begin
            do_reg(f3s[i], 5'd8, 5'd6, 5'd7);
         end
         do_imm(3'b010, 5'd9, 5'd6, 12'(lcg_next() >> 20));
         do_imm(3'b011, 5'd9, 5'd6, 12'(lcg_next() >> 20));
      end
      // the x0 write must not stick, so x10 gets x6 unchanged
      do_reg(3'b000, 5'd0, 5'd6, 5'd7);
      do_reg(3'b000, 5'd10, 5'd0, 5'd6);
   endtask

   task automatic test_upper_jump();
      logic [19:0] imm20;
      logic [63:0] upper;
      imm20 = {1'b1, 19'(lcg_next() >> 13)};
      upper = {{32{imm20[19]}}, imm20, 12'd0};
      run_insn({imm20, 5'd10, OP_LUI}, 1'b1, upper, exp_pc + 4);
      run_insn({imm20, 5'd11, OP_AUIPC}, 1'b1, exp_pc + upper, exp_pc + 4);
      run_insn(enc_j(21'd16, 5'd1), 1'b1, exp_pc + 4, exp_pc + 16);
      run_insn(enc_j(21'h1ffff8, 5'd1), 1'b1, exp_pc + 4, exp_pc - 8);
      do_imm(3'b000, 5'd3, 5'd0, 12'h123);
      run_insn(enc_i(12'h00a, 5'd3, 3'b000, 5'd2, OP_JALR), 1'b1, exp_pc + 4,
               (regs[3] + 64'h00a) & ~64'h1);
   endtask

   task automatic test_branches();
      logic [2:0] f3s [6];
      f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      do_imm(3'b000, 5'd11, 5'd0, 12'hffd);
      do_imm(3'b000, 5'd12, 5'd0, 12'h004);
      for (int i = 0; i < 6; i++) begin
         do_branch(f3s[i], 5'd11, 5'd12, 13'd20);
         do_branch(f3s[i], 5'd12, 5'd11, 13'h1ff4);
         do_branch(f3s[i], 5'd11, 5'd11, 13'd8);
      end
   endtask

   task automatic test_memory();
      logic [31:0] r;
      repeat (6) begin
         r = lcg_next();
         do_imm(3'b000, 5'd13, 5'd0, {1'b0, r[23:16], 3'b000});
         load_random(5'd14);
         load_random(5'd15);
         do_store(3'b011, 5'd14, 3'd0);
         do_store(3'b000, 5'd15, r[2:0]);
         do_store(3'b001, 5'd15, {r[4:3], 1'b0});
         do_store(3'b010, 5'd15, {r[5], 2'b00});
         do_load(3'b000, 5'd16, r[8:6]);
         do_load(3'b100, 5'd16, r[11:9]);
         do_load(3'b001, 5'd16, {r[13:12], 1'b0});
         do_load(3'b101, 5'd16, {r[15:14], 1'b0});
         do_load(3'b010, 5'd16, {r[24], 2'b00});
         do_load(3'b110, 5'd16, {r[25], 2'b00});
         do_load(3'b011, 5'd16, 3'd0);
      end
   endtask

   // x13 still points at a doubleword that the memory test wrote
   task automatic test_backpressure();
      logic [31:0] ld_word;
      logic [31:0] addi_word;
      int cycles;
      ld_word = enc_i(12'd0, 5'd13, 3'b011, 5'd17, OP_LOAD);
      addi_word = enc_i(12'h011, 5'd0, 3'b000, 5'd18, OP_IMM);
      repeat (4) begin
         cycles = 0;
         send_insn(ld_word);
         i_insn_valid <= 1'b1;
         i_insn <= addi_word;
         @(negedge clk);
         while (!o_retire.valid) begin
            check("o_insn_ready", o_insn_ready, 1'b0);
            cycles++;
            if (cycles > 200) fail_timeout("the load never retired");
            @(negedge clk);
         end
         check_retire(ld_word, 1'b1, load_ref(3'b011, exp_mem[regs[13][11:3]], 3'd0),
                      exp_pc + 4);
         check("o_insn_ready", o_insn_ready, 1'b1);
         @(posedge clk);
         i_insn_valid <= 1'b0;
         wait_retire();
         check_retire(addi_word, 1'b1, 64'h11, exp_pc + 4);
      end
   endtask

   initial begin
      i_reset = 1'b1;
      i_insn_valid = 1'b0;
      i_insn = '0;
      exp_pc = RESET_PC;
      for (int i = 0; i < 32; i++) begin
         regs[i] = 64'd0;
      end
      repeat (16) @(posedge clk);
      i_reset <= 1'b0;
      @(negedge clk);
      test_reset_addi();
      test_alu_random();
      test_upper_jump();
      test_branches();
      test_memory();
      test_backpressure();
      if (err_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_apb_mem.sv ====
`default_nettype none

module tb_apb_mem (
   input  logic             i_clk,
   input  logic             i_reset,
   input  rv_pkg::apb_req_t i_req,
   output rv_pkg::apb_rsp_t o_rsp
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [63:0] mem [512];
   logic [1:0] wait_cnt;
   logic [31:0] lcg_state;
   wire [8:0] idx = i_req.paddr[11:3];

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // every doubleword starts with a value derived from its full index
   initial begin
      for (int i = 0; i < 512; i++) begin
         mem[i] = 64'h0123_4567_89ab_cdef ^ (64'(i) * 64'h9e37_79b9_7f4a_7c15);
      end
   end

   always @(posedge i_clk) begin
      if (i_reset) begin
         wait_cnt <= 2'd0;
         lcg_state <= 32'd60721;
      end else if (i_req.psel && !i_req.penable) begin
         // the setup phase draws the wait-state count for this transfer
         lcg_state <= lcg_step(lcg_state);
         wait_cnt <= lcg_state[17:16];
      end else if (i_req.psel && i_req.penable) begin
         if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else if (i_req.pwrite) begin
            for (int b = 0; b < 8; b++) begin
               if (i_req.pstrb[b]) begin
                  mem[idx][8*b +: 8] <= i_req.pwdata[8*b +: 8];
               end
            end
         end
      end
   end

   assign o_rsp.pready = i_req.psel && i_req.penable && (wait_cnt == 2'd0);
   assign o_rsp.prdata = mem[idx];
   assign o_rsp.pslverr = 1'b0;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core #(
   parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic                    i_insn_valid,
   input  rv_pkg::insn_u           i_insn,
   output logic                    o_insn_ready,
   output rv_pkg::apb_req_t        o_apb,
   input  rv_pkg::apb_rsp_t        i_apb,
   output rv_pkg::retire_t         o_retire,
   output logic [rv_pkg::XLEN-1:0] o_pc
);

   rv_pkg::insn_u insn_q;
   rv_pkg::decode_t dec;
   rv_pkg::retire_t retire_q;
   logic busy;
   logic issue;
   logic [rv_pkg::XLEN-1:0] pc_q;
   logic [rv_pkg::XLEN-1:0] rs1_data;
   logic [rv_pkg::XLEN-1:0] rs2_data;
   logic [rv_pkg::XLEN-1:0] alu_result;
   logic [rv_pkg::XLEN-1:0] next_pc;
   logic [rv_pkg::XLEN-1:0] load_data;
   logic [rv_pkg::XLEN-1:0] wb_data;
   logic accept;
   logic is_mem;
   logic lsu_start;
   logic lsu_done;
   logic retire_now;

   assign accept = i_insn_valid && !busy;
   assign is_mem = dec.is_load || dec.is_store;
   // issue is high only in the first cycle an instruction sits in insn_q
   assign lsu_start = issue && dec.valid && is_mem;
   assign retire_now = (issue && !is_mem) || lsu_done;
   assign wb_data = dec.is_load ? load_data : alu_result;

   always_ff @(posedge i_clk) begin
      if (accept) begin
         insn_q <= i_insn;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         busy <= 1'b0;
         issue <= 1'b0;
         pc_q <= RESET_PC;
         retire_q <= '0;
      end else begin
         issue <= accept;
         retire_q.valid <= retire_now;
         if (accept) begin
            busy <= 1'b1;
         end else if (retire_now) begin
            busy <= 1'b0;
         end
         if (retire_now) begin
            pc_q <= next_pc;
            retire_q.pc <= pc_q;
            retire_q.next_pc <= next_pc;
            retire_q.rd <= dec.rd;
            retire_q.we <= dec.rf_we;
            retire_q.wdata <= wb_data;
         end
      end
   end

   rv_idu rv_idu_inst (
      .i_insn  (insn_q),
      .i_valid (busy),
      .o_dec   (dec)
   );

   rv_regfile rv_regfile_inst (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_rs1      (dec.rs1),
      .i_rs2      (dec.rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (retire_now && dec.rf_we),
      .i_rd       (dec.rd),
      .i_wdata    (wb_data)
   );

   rv_alu rv_alu_inst (
      .i_dec      (dec),
      .i_pc       (pc_q),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_result   (alu_result),
      .o_next_pc  (next_pc)
   );

   rv_lsu rv_lsu_inst (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_start (lsu_start),
      .i_dec   (dec),
      .i_addr  (alu_result),
      .i_wdata (rs2_data),
      .o_apb   (o_apb),
      .i_apb   (i_apb),
      .o_done  (lsu_done),
      .o_rdata (load_data)
   );

   assign o_insn_ready = !busy;
   assign o_retire = retire_q;
   assign o_pc = pc_q;

endmodule

`default_nettype wire

// ==== rv_lsu.sv ====
`default_nettype none

module rv_lsu (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic                    i_start,
   input  rv_pkg::decode_t         i_dec,
   input  logic [rv_pkg::XLEN-1:0] i_addr,
   input  logic [rv_pkg::XLEN-1:0] i_wdata,
   output rv_pkg::apb_req_t        o_apb,
   input  rv_pkg::apb_rsp_t        i_apb,
   output logic                    o_done,
   output logic [rv_pkg::XLEN-1:0] o_rdata
);

   typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS} state_e;

   state_e state;
   logic psel_q;
   logic penable_q;
   logic pwrite_q;
   logic [31:0] paddr_q;
   logic [63:0] pwdata_q;
   logic [7:0] pstrb_q;
   logic [7:0] strb_base;
   logic [rv_pkg::XLEN-1:0] load_word;

   always_comb begin
      unique case (i_dec.lsu_size)
         rv_pkg::SZ_BYTE: strb_base = 8'h01;
         rv_pkg::SZ_HALF: strb_base = 8'h03;
         rv_pkg::SZ_WORD: strb_base = 8'h0f;
         default:         strb_base = 8'hff;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= S_IDLE;
         psel_q <= 1'b0;
         penable_q <= 1'b0;
      end else begin
         unique case (state)
            S_IDLE: begin
               if (i_start) begin
                  psel_q <= 1'b1;
                  state <= S_SETUP;
               end
            end
            S_SETUP: begin
               penable_q <= 1'b1;
               state <= S_ACCESS;
            end
            S_ACCESS: begin
               if (i_apb.pready) begin
                  psel_q <= 1'b0;
                  penable_q <= 1'b0;
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // store data and strobes move onto the lanes picked by the low address bits
   always_ff @(posedge i_clk) begin
      if ((state == S_IDLE) && i_start) begin
         paddr_q <= i_addr[31:0];
         pwrite_q <= i_dec.is_store;
         pwdata_q <= i_wdata << {i_addr[2:0], 3'b000};
         pstrb_q <= i_dec.is_store ? (strb_base << i_addr[2:0]) : 8'h00;
      end
   end

   assign o_apb.psel = psel_q;
   assign o_apb.penable = penable_q;
   assign o_apb.pwrite = pwrite_q;
   assign o_apb.paddr = paddr_q;
   assign o_apb.pwdata = pwdata_q;
   assign o_apb.pstrb = pstrb_q;

   assign o_done = (state == S_ACCESS) && i_apb.pready;

   always_comb begin
      load_word = i_apb.prdata >> {paddr_q[2:0], 3'b000};
      unique case (i_dec.lsu_size)
         rv_pkg::SZ_BYTE: begin
            o_rdata = {{(rv_pkg::XLEN-8){i_dec.lsu_sigext & load_word[7]}}, load_word[7:0]};
         end
         rv_pkg::SZ_HALF: begin
            o_rdata = {{(rv_pkg::XLEN-16){i_dec.lsu_sigext & load_word[15]}}, load_word[15:0]};
         end
         rv_pkg::SZ_WORD: begin
            o_rdata = {{(rv_pkg::XLEN-32){i_dec.lsu_sigext & load_word[31]}}, load_word[31:0]};
         end
         default: o_rdata = load_word;
      endcase
   end

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`default_nettype none

module rv_alu (
   input  rv_pkg::decode_t         i_dec,
   input  logic [rv_pkg::XLEN-1:0] i_pc,
   input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
   input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
   output logic [rv_pkg::XLEN-1:0] o_result,
   output logic [rv_pkg::XLEN-1:0] o_next_pc
);

   logic [rv_pkg::XLEN-1:0] opnd_b;
   logic [rv_pkg::XLEN-1:0] pc_plus4;
   logic [rv_pkg::XLEN-1:0] jalr_sum;
   logic taken;

   always_comb begin
      unique case (i_dec.opnd_sel)
         rv_pkg::OPND_RF:  opnd_b = i_rs2_data;
         rv_pkg::OPND_IMM: opnd_b = i_dec.imm;
         default:          opnd_b = '0;
      endcase
   end

   assign pc_plus4 = i_pc + 4;
   assign jalr_sum = i_rs1_data + i_dec.imm;

   always_comb begin
      unique case (i_dec.alu_op)
         rv_pkg::ALU_LUI:   o_result = i_dec.imm;
         rv_pkg::ALU_AUIPC: o_result = i_pc + i_dec.imm;
         rv_pkg::ALU_JAL,
         rv_pkg::ALU_JALR:  o_result = pc_plus4;
         rv_pkg::ALU_ADD:   o_result = i_rs1_data + opnd_b;
         rv_pkg::ALU_OR:    o_result = i_rs1_data | opnd_b;
         rv_pkg::ALU_SLL:   o_result = i_rs1_data << opnd_b[5:0];
         // one select each serves the register and the immediate compare
         rv_pkg::ALU_SLTI: begin
            o_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(i_rs1_data) < $signed(opnd_b)};
         end
         rv_pkg::ALU_SLTIU: begin
            o_result = {{(rv_pkg::XLEN-1){1'b0}}, i_rs1_data < opnd_b};
         end
         default:           o_result = '0;
      endcase
   end

   // branches compare the two registers directly
   always_comb begin
      unique case (i_dec.alu_op)
         rv_pkg::ALU_BEQ:  taken = (i_rs1_data == i_rs2_data);
         rv_pkg::ALU_BNE:  taken = (i_rs1_data != i_rs2_data);
         rv_pkg::ALU_BLT:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
         rv_pkg::ALU_BGE:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
         rv_pkg::ALU_BLTU: taken = (i_rs1_data < i_rs2_data);
         rv_pkg::ALU_BGEU: taken = (i_rs1_data >= i_rs2_data);
         rv_pkg::ALU_JAL:  taken = 1'b1;
         default:          taken = 1'b0;
      endcase
   end

   always_comb begin
      if (i_dec.alu_op == rv_pkg::ALU_JALR) begin
         o_next_pc = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
      end else if (taken && i_dec.is_branch_or_jump) begin
         o_next_pc = i_pc + i_dec.imm;
      end else begin
         o_next_pc = pc_plus4;
      end
   end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`default_nettype none

module rv_regfile (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic [4:0]              i_rs1,
   input  logic [4:0]              i_rs2,
   output logic [rv_pkg::XLEN-1:0] o_rs1_data,
   output logic [rv_pkg::XLEN-1:0] o_rs2_data,
   input  logic                    i_we,
   input  logic [4:0]              i_rd,
   input  logic [rv_pkg::XLEN-1:0] i_wdata
);

   logic [rv_pkg::XLEN-1:0] regs [32];

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_rd != 5'd0)) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // x0 always reads as zero
   assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== rv_idu.sv ====
`default_nettype none

module rv_idu (
   input  rv_pkg::insn_u   i_insn,
   input  logic            i_valid,
   output rv_pkg::decode_t o_dec
);

   wire [2:0] funct3 = i_insn.r.funct3;
   wire f7_zero = (i_insn.r.funct7 == 7'b0000000);
   wire f7_alt = (i_insn.r.funct7 == 7'b0100000);

   wire opc_branch = (i_insn.r.opcode == rv_pkg::OPC_BRANCH);
   wire opc_load = (i_insn.r.opcode == rv_pkg::OPC_LOAD);
   wire opc_store = (i_insn.r.opcode == rv_pkg::OPC_STORE);
   wire opc_op_imm = (i_insn.r.opcode == rv_pkg::OPC_OP_IMM);
   wire opc_op = (i_insn.r.opcode == rv_pkg::OPC_OP);
   wire opc_op_imm_32 = (i_insn.r.opcode == rv_pkg::OPC_OP_IMM_32);
   wire opc_op_32 = (i_insn.r.opcode == rv_pkg::OPC_OP_32);

   wire op_lui = (i_insn.r.opcode == rv_pkg::OPC_LUI);
   wire op_auipc = (i_insn.r.opcode == rv_pkg::OPC_AUIPC);
   wire op_jal = (i_insn.r.opcode == rv_pkg::OPC_JAL);
   wire op_jalr = (i_insn.r.opcode == rv_pkg::OPC_JALR) & (funct3 == 3'b000);
   wire op_beq = opc_branch & (funct3 == 3'b000);
   wire op_bne = opc_branch & (funct3 == 3'b001);
   wire op_blt = opc_branch & (funct3 == 3'b100);
   wire op_bge = opc_branch & (funct3 == 3'b101);
   wire op_bltu = opc_branch & (funct3 == 3'b110);
   wire op_bgeu = opc_branch & (funct3 == 3'b111);
   wire op_lb = opc_load & (funct3 == 3'b000);
   wire op_lh = opc_load & (funct3 == 3'b001);
   wire op_lw = opc_load & (funct3 == 3'b010);
   wire op_ld = opc_load & (funct3 == 3'b011);
   wire op_lbu = opc_load & (funct3 == 3'b100);
   wire op_lhu = opc_load & (funct3 == 3'b101);
   wire op_lwu = opc_load & (funct3 == 3'b110);
   wire op_sb = opc_store & (funct3 == 3'b000);
   wire op_sh = opc_store & (funct3 == 3'b001);
   wire op_sw = opc_store & (funct3 == 3'b010);
   wire op_sd = opc_store & (funct3 == 3'b011);
   wire op_addi = opc_op_imm & (funct3 == 3'b000);
   wire op_slti = opc_op_imm & (funct3 == 3'b010);
   wire op_sltiu = opc_op_imm & (funct3 == 3'b011);
   wire op_ori = opc_op_imm & (funct3 == 3'b110);
   wire op_slli = opc_op_imm & f7_zero & (funct3 == 3'b001);
   wire op_add = opc_op & f7_zero & (funct3 == 3'b000);
   wire op_sll = opc_op & f7_zero & (funct3 == 3'b001);
   wire op_slt = opc_op & f7_zero & (funct3 == 3'b010);
   wire op_sltu = opc_op & f7_zero & (funct3 == 3'b011);
   wire op_or = opc_op & f7_zero & (funct3 == 3'b110);

   // recognised encodings that carry no ALU operation here
   wire op_imm_other = opc_op_imm & ((funct3 == 3'b100) | (funct3 == 3'b111) |
                                     ((funct3 == 3'b101) & (f7_zero | f7_alt)));
   wire op_r_other = opc_op & ((f7_zero & ((funct3 == 3'b100) | (funct3 == 3'b101) |
                                           (funct3 == 3'b111))) |
                               (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101))));
   wire op_imm_32 = opc_op_imm_32 & ((funct3 == 3'b000) | (f7_zero & (funct3 == 3'b001)) |
                                     ((f7_zero | f7_alt) & (funct3 == 3'b101)));
   wire op_r_32 = opc_op_32 & (((f7_zero | f7_alt) & (funct3 == 3'b000)) |
                               (f7_zero & (funct3 == 3'b001)) |
                               ((f7_zero | f7_alt) & (funct3 == 3'b101)));

   wire op_load = op_lb | op_lbu | op_lh | op_lhu | op_lw | op_lwu | op_ld;
   wire op_store = op_sb | op_sh | op_sw | op_sd;

   wire r_type = op_add | op_sll | op_slt | op_sltu | op_or | op_r_other | op_r_32;
   wire i_type = op_jalr | op_load | op_addi | op_slti | op_sltiu | op_ori | op_slli |
                 op_imm_other | op_imm_32;
   wire b_type = op_beq | op_bne | op_blt | op_bge | op_bltu | op_bgeu;
   wire u_type = op_lui | op_auipc;

   rv_pkg::alu_op_e alu_op;
   logic [rv_pkg::XLEN-1:0] imm;

   always_comb begin
      alu_op = rv_pkg::ALU_NONE;
      if (op_lui) alu_op = rv_pkg::ALU_LUI;
      else if (op_auipc) alu_op = rv_pkg::ALU_AUIPC;
      else if (op_jal) alu_op = rv_pkg::ALU_JAL;
      else if (op_jalr) alu_op = rv_pkg::ALU_JALR;
      else if (op_beq) alu_op = rv_pkg::ALU_BEQ;
      else if (op_bne) alu_op = rv_pkg::ALU_BNE;
      else if (op_blt) alu_op = rv_pkg::ALU_BLT;
      else if (op_bge) alu_op = rv_pkg::ALU_BGE;
      else if (op_bltu) alu_op = rv_pkg::ALU_BLTU;
      else if (op_bgeu) alu_op = rv_pkg::ALU_BGEU;
      // the adder also forms load and store addresses
      else if (op_add | op_addi | op_load | op_store) alu_op = rv_pkg::ALU_ADD;
      else if (op_or | op_ori) alu_op = rv_pkg::ALU_OR;
      else if (op_sll | op_slli) alu_op = rv_pkg::ALU_SLL;
      else if (op_slt | op_slti) alu_op = rv_pkg::ALU_SLTI;
      else if (op_sltu | op_sltiu) alu_op = rv_pkg::ALU_SLTIU;
   end

   always_comb begin
      imm = '0;
      if (i_type) begin
         imm = {{(rv_pkg::XLEN-12){i_insn.i.imm11_0[11]}}, i_insn.i.imm11_0};
      end else if (op_store) begin
         imm = {{(rv_pkg::XLEN-12){i_insn.s.imm11_5[6]}}, i_insn.s.imm11_5, i_insn.s.imm4_0};
      end else if (b_type) begin
         imm = {{(rv_pkg::XLEN-13){i_insn.b.imm12}}, i_insn.b.imm12, i_insn.b.imm11,
                i_insn.b.imm10_5, i_insn.b.imm4_1, 1'b0};
      end else if (u_type) begin
         imm = {{(rv_pkg::XLEN-32){i_insn.u.imm31_12[19]}}, i_insn.u.imm31_12, 12'b0};
      end else if (op_jal) begin
         imm = {{(rv_pkg::XLEN-21){i_insn.j.imm20}}, i_insn.j.imm20, i_insn.j.imm19_12,
                i_insn.j.imm11, i_insn.j.imm10_1, 1'b0};
      end
   end

   assign o_dec.valid = i_valid;
   assign o_dec.alu_op = alu_op;
   assign o_dec.opnd_sel = r_type ? rv_pkg::OPND_RF :
                           (i_type | op_store | u_type) ? rv_pkg::OPND_IMM :
                           rv_pkg::OPND_NONE;
   assign o_dec.rs1 = i_insn.r.rs1;
   assign o_dec.rs2 = (r_type | op_store | b_type) ? i_insn.r.rs2 : 5'd0;
   assign o_dec.rd = i_insn.r.rd;
   assign o_dec.rf_we = (r_type | i_type | u_type | op_jal) & (alu_op != rv_pkg::ALU_NONE);
   assign o_dec.is_load = op_load;
   assign o_dec.is_store = op_store;
   assign o_dec.lsu_size = (op_lb | op_lbu | op_sb) ? rv_pkg::SZ_BYTE :
                           (op_lh | op_lhu | op_sh) ? rv_pkg::SZ_HALF :
                           (op_lw | op_lwu | op_sw) ? rv_pkg::SZ_WORD :
                           rv_pkg::SZ_DWORD;
   assign o_dec.lsu_sigext = op_lb | op_lh | op_lw;
   assign o_dec.imm = imm;
   assign o_dec.is_branch_or_jump = b_type | op_jal | op_jalr;

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

   localparam int XLEN = 64;

   typedef enum logic [6:0] {
      OPC_LUI       = 7'b0110111,
      OPC_AUIPC     = 7'b0010111,
      OPC_JAL       = 7'b1101111,
      OPC_JALR      = 7'b1100111,
      OPC_BRANCH    = 7'b1100011,
      OPC_LOAD      = 7'b0000011,
      OPC_STORE     = 7'b0100011,
      OPC_OP_IMM    = 7'b0010011,
      OPC_OP        = 7'b0110011,
      OPC_OP_IMM_32 = 7'b0011011,
      OPC_OP_32     = 7'b0111011
   } opcode_e;

   // encoded replacement for the one-hot functional unit select
   typedef enum logic [4:0] {
      ALU_NONE, ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
      ALU_ADD, ALU_OR, ALU_SLL, ALU_SLTI, ALU_SLTIU
   } alu_op_e;

   typedef enum logic [1:0] {OPND_RF, OPND_IMM, OPND_NONE} opnd_sel_e;

   typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD, SZ_DWORD} lsu_size_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      opcode_e    opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_e    opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      opcode_e     opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcode_e    opcode;
   } j_fmt_t;

   // one instruction word seen through each of the six base formats
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } insn_u;

   typedef struct packed {
      logic            valid;
      alu_op_e         alu_op;
      opnd_sel_e       opnd_sel;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [4:0]      rd;
      logic            rf_we;
      logic            is_load;
      logic            is_store;
      lsu_size_e       lsu_size;
      logic            lsu_sigext;
      logic [XLEN-1:0] imm;
      logic            is_branch_or_jump;
   } decode_t;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] next_pc;
      logic [4:0]      rd;
      logic            we;
      logic [XLEN-1:0] wdata;
   } retire_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] paddr;
      logic [63:0] pwdata;
      logic [7:0]  pstrb;
   } apb_req_t;

   typedef struct packed {
      logic        pready;
      logic [63:0] prdata;
      logic        pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire
